//--- Makefile
VERILATOR ?= verilator
TOP ?= uart_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
uart_pkg.sv
sync_fifo.sv
uart_transmitter.sv
uart_receiver.sv
uart_wb_regs.sv
uart_top.sv
uart_tb.sv

//--- sync_fifo.sv
module sync_fifo (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           clear,
	input  logic                           push,
	input  logic [uart_pkg::DATA_BITS-1:0] push_data,
	input  logic                           pop,
	output logic [uart_pkg::DATA_BITS-1:0] pop_data,
	output uart_pkg::fifo_stat_t           stat
);
	import uart_pkg::*;

	logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	logic [FIFO_CNT_BITS-1:0] count;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
	assign empty = (count == '0);

	// Push when full and pop when empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap naturally at depth 16
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			// Clear beats push and pop
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is valid whenever not empty
	assign pop_data = mem[rd_ptr];

	assign stat.count = count;
	assign stat.full = full;
	assign stat.empty = empty;

	a_count_range: assert property (@(posedge clock) disable iff (!rst_n)
		count <= FIFO_DEPTH);

	// Pointer distance agrees with the occupancy count
	a_ptr_count: assert property (@(posedge clock) disable iff (!rst_n)
		FIFO_PTR_BITS'(wr_ptr - rd_ptr) == count[FIFO_PTR_BITS-1:0]);

endmodule

//--- uart_pkg.sv
package uart_pkg;

	// System clock in Hz
	localparam int CLOCK_HZ = 50_000_000;

	// Character and FIFO sizing
	localparam int DATA_BITS = 8;
	localparam int BIT_IDX_BITS = $clog2(DATA_BITS);
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	// Count holds 0 to FIFO_DEPTH
	localparam int FIFO_CNT_BITS = 5;

	// Wide enough for the 110 baud divisor
	localparam int BAUD_DIV_BITS = 19;

	// Clock cycles per bit, rounded to nearest
	function automatic logic [BAUD_DIV_BITS-1:0] baud_div(input int rate);
		return BAUD_DIV_BITS'((CLOCK_HZ + rate / 2) / rate);
	endfunction

	// Indexed by the CTRL baud code
	localparam logic [BAUD_DIV_BITS-1:0] baud_div_table [16] = '{
		baud_div(9600),
		baud_div(110),
		baud_div(300),
		baud_div(600),
		baud_div(1200),
		baud_div(2400),
		baud_div(4800),
		baud_div(14400),
		baud_div(19200),
		baud_div(38400),
		baud_div(57600),
		baud_div(115200),
		baud_div(230400),
		baud_div(460800),
		// 54 cycles per bit
		baud_div(921600),
		// Reserved code, same as 9600
		baud_div(9600)
	};

	// Word offsets, decoded from adr[3:2]
	typedef enum logic [1:0] {
		REG_DATA   = 2'd0,
		REG_STATUS = 2'd1,
		REG_CTRL   = 2'd2
	} reg_addr_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// Field order matches CTRL bits [7:0]
	typedef struct packed {
		logic       irq_tx_en;
		logic       irq_rx_en;
		logic       rx_en;
		logic       tx_en;
		logic [3:0] baud;
	} uart_ctrl_t;

	typedef struct packed {
		logic [FIFO_CNT_BITS-1:0] count;
		logic                     full;
		logic                     empty;
	} fifo_stat_t;

endpackage

//--- uart_receiver.sv
module uart_receiver (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               enable,
	input  logic [uart_pkg::BAUD_DIV_BITS-1:0] divisor,
	input  logic                               rxd,
	input  uart_pkg::fifo_stat_t               fifo_stat,
	output logic                               fifo_push,
	output logic [uart_pkg::DATA_BITS-1:0]     fifo_data,
	output logic                               overrun,
	output logic                               frame_err
);
	import uart_pkg::*;

	rx_state_e state;
	logic rxd_meta;
	logic rxd_sync;
	// Previous synced level, for the falling edge
	logic rxd_prev;
	logic [BAUD_DIV_BITS-1:0] cnt;
	logic [BAUD_DIV_BITS-1:0] bit_div;
	logic [BIT_IDX_BITS-1:0] bit_idx;
	logic [DATA_BITS-1:0] shreg;
	logic start_edge;
	logic half_end;
	logic bit_end;

	// Two-flop synchronizer, idle level is high
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev && !rxd_sync;
	// Middle of the start bit
	assign half_end = (cnt == (bit_div >> 1) - 1'b1);
	assign bit_end = (cnt == bit_div - 1'b1);

	// Divisor latched per frame, data shifted in LSB first
	always_ff @(posedge clock) begin
		if (state == RX_IDLE && start_edge) begin
			bit_div <= divisor;
		end
		if (state == RX_DATA && bit_end) begin
			shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
		end
	end

	// Stable until the next frame reaches RX_DATA
	assign fifo_data = shreg;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			fifo_push <= 1'b0;
			overrun <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			// Event outputs are single-cycle pulses
			fifo_push <= 1'b0;
			overrun <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (start_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (half_end) begin
						cnt <= '0;
						bit_idx <= '0;
						// Glitch, not a start bit
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == BIT_IDX_BITS'(DATA_BITS - 1)) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						// Back to idle at mid stop bit
						state <= RX_IDLE;
						cnt <= '0;
						if (enable) begin
							if (!rxd_sync) begin
								frame_err <= 1'b1;
							end else if (fifo_stat.full) begin
								overrun <= 1'b1;
							end else begin
								fifo_push <= 1'b1;
							end
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Push is decided a cycle early, room must still be there
	a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
		fifo_push |-> !fifo_stat.full);

endmodule

//--- uart_tb.sv
module uart_tb;
	import uart_pkg::*;

	// Baud code 14, 54 cycles per bit, 10 bits per frame
	localparam int BIT_CYCLES = 54;
	localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
	// About 40 frames plus margin
	localparam int MAX_CYCLES = 40_000;
	localparam int ACK_LIMIT = 4;
	localparam int POLL_LIMIT = 2000;

	// Byte addresses of the registers
	localparam logic [3:0] ADDR_DATA = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;
	localparam logic [3:0] ADDR_CTRL = 4'h8;

	// CTRL values: baud 14 plus enables
	localparam logic [31:0] CTRL_TXRX = 32'h0000_003E;
	localparam logic [31:0] CTRL_RX_ONLY = 32'h0000_002E;
	localparam logic [31:0] CTRL_OFF = 32'h0000_000E;
	localparam logic [31:0] CTRL_IRQ_RX = 32'h0000_007E;
	localparam logic [31:0] CTRL_IRQ_TX = 32'h0000_00BE;
	localparam logic [31:0] CTRL_TX_CLEAR = 32'h0000_010E;

	logic clock;
	logic rst_n;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	logic txd;
	logic rxd;
	logic irq;

	// Serial line of the frame injector
	logic inject;
	logic inj_line;
	logic [7:0] stim_bytes [17];
	integer seed;
	int cycles;

	// Loopback unless the injector owns the line
	assign rxd = inject ? inj_line : txd;

	uart_top uut (
		.clock   (clock),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.txd     (txd),
		.rxd     (rxd),
		.irq     (irq)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Hard stop for a hung run
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run exceeded %0d clock cycles without finishing", MAX_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s = %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// STATUS layout from the register map
	function automatic logic [31:0] status_word(input int tx_cnt, input int rx_cnt,
		input logic tx_full, input logic rx_empty, input logic tx_busy,
		input logic ovr, input logic ferr);
		logic [31:0] w;
		w = '0;
		w[4:0] = tx_cnt[4:0];
		w[12:8] = rx_cnt[4:0];
		w[16] = tx_full;
		w[17] = rx_empty;
		w[18] = tx_busy;
		w[19] = ovr;
		w[20] = ferr;
		return w;
	endfunction

	// One classic cycle, request held through the ack cycle
	task automatic bus_cycle(input logic we, input logic [3:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		n = 0;
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = we;
		bus_req.adr = adr;
		bus_req.dat = wdata;
		@(posedge clock);
		#2;
		while (!bus_rsp.ack) begin
			n++;
			if (n >= ACK_LIMIT) begin
				$display("No ack from the bus slave within %0d cycles at %0t", ACK_LIMIT, $time);
				$display("TEST FAIL");
				$fatal(1, "bus ack missing");
			end
			@(posedge clock);
			#2;
		end
		rdata = bus_rsp.dat;
		@(posedge clock);
		#2;
		bus_req = '0;
	endtask

	task automatic write_reg(input logic [3:0] adr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, wdata, unused);
	endtask

	task automatic read_reg(input logic [3:0] adr, output logic [31:0] rdata);
		bus_cycle(1'b0, adr, 32'd0, rdata);
	endtask

	// Poll STATUS until the masked fields match
	task automatic poll_status(input logic [31:0] mask, input logic [31:0] value,
		output logic [31:0] word);
		int n;
		n = 0;
		read_reg(ADDR_STATUS, word);
		while ((word & mask) !== value) begin
			n++;
			if (n > POLL_LIMIT) begin
				$display("STATUS never reached %h under mask %h, last %h", value, mask, word);
				$display("TEST FAIL");
				$fatal(1, "status poll expired");
			end
			read_reg(ADDR_STATUS, word);
		end
	endtask

	// irq is registered, so skip one cycle of stale value first
	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		@(posedge clock);
		#2;
		while (irq !== level) begin
			n++;
			if (n > limit) begin
				$display("irq did not go to %0b within %0d cycles at %0t", level, limit, $time);
				$display("TEST FAIL");
				$fatal(1, "irq wait expired");
			end
			@(posedge clock);
			#2;
		end
	endtask

	// 8N1 frame on the injector line, LSB first, then one idle bit
	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		inj_line = 1'b0;
		repeat (BIT_CYCLES) @(posedge clock);
		#2;
		for (int b = 0; b < 8; b++) begin
			inj_line = data[b];
			repeat (BIT_CYCLES) @(posedge clock);
			#2;
		end
		inj_line = stop_level;
		repeat (BIT_CYCLES) @(posedge clock);
		#2;
		inj_line = 1'b1;
		repeat (BIT_CYCLES) @(posedge clock);
		#2;
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] st;
		rst_n = 1'b0;
		bus_req = '0;
		inject = 1'b0;
		inj_line = 1'b1;
		cycles = 0;
		seed = 32'h8ab5;
		stim_bytes[0] = 8'h00;
		stim_bytes[1] = 8'hFF;
		stim_bytes[2] = 8'h55;
		stim_bytes[3] = 8'hA5;
		for (int i = 4; i < 17; i++) begin
			stim_bytes[i] = 8'($random(seed));
		end
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;

		// Reset state
		check("txd", {31'd0, txd}, 32'd1);
		check("irq", {31'd0, irq}, 32'd0);
		read_reg(ADDR_CTRL, rd);
		check("ctrl", rd, 32'd0);
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		// Loopback of four bytes
		write_reg(ADDR_CTRL, CTRL_TXRX);
		read_reg(ADDR_CTRL, rd);
		check("ctrl", rd, CTRL_TXRX);
		for (int i = 0; i < 4; i++) begin
			write_reg(ADDR_DATA, {24'd0, stim_bytes[i]});
		end
		poll_status(32'h0000_1F00, 32'h0000_0400, st);
		for (int i = 0; i < 4; i++) begin
			read_reg(ADDR_DATA, rd);
			check("rx data", rd, {24'd0, stim_bytes[i]});
		end
		// Stop bit of the last frame may still be on the line
		poll_status(32'h0004_001F, 32'd0, st);
		check("status", st, status_word(0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		// TX FIFO fills to 16 with the engine off
		write_reg(ADDR_CTRL, CTRL_OFF);
		for (int i = 0; i < 17; i++) begin
			write_reg(ADDR_DATA, {24'd0, stim_bytes[i]});
		end
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(16, 0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
		write_reg(ADDR_CTRL, CTRL_TX_CLEAR);
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		read_reg(ADDR_CTRL, rd);
		check("ctrl", rd, CTRL_OFF);
		read_reg(ADDR_DATA, rd);
		check("rx data", rd, 32'd0);

		// Overrun, batches of 8, tx idle seen through irq
		write_reg(ADDR_CTRL, CTRL_IRQ_TX);
		for (int i = 0; i < 17; i++) begin
			write_reg(ADDR_DATA, {24'd0, stim_bytes[i]});
			if ((i % 8) == 7 || i == 16) begin
				wait_irq(1'b1, 10 * FRAME_CYCLES);
			end
		end
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 16, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 16, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		for (int i = 0; i < 16; i++) begin
			read_reg(ADDR_DATA, rd);
			check("rx data", rd, {24'd0, stim_bytes[i]});
		end

		// Framing error, then a good frame
		write_reg(ADDR_CTRL, CTRL_RX_ONLY);
		inject = 1'b1;
		for (int i = 4; i < 8; i++) begin
			send_frame(stim_bytes[i], 1'b0);
			read_reg(ADDR_STATUS, rd);
			check("status", rd, status_word(0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
			send_frame(stim_bytes[i], 1'b1);
			poll_status(32'h0000_1F00, 32'h0000_0100, st);
			check("status", st, status_word(0, 1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
			read_reg(ADDR_DATA, rd);
			check("rx data", rd, {24'd0, stim_bytes[i]});
		end
		inject = 1'b0;

		// Receive interrupt
		write_reg(ADDR_CTRL, CTRL_IRQ_RX);
		check("irq", {31'd0, irq}, 32'd0);
		write_reg(ADDR_DATA, {24'd0, stim_bytes[16]});
		wait_irq(1'b1, 2 * FRAME_CYCLES);
		read_reg(ADDR_DATA, rd);
		check("rx data", rd, {24'd0, stim_bytes[16]});
		wait_irq(1'b0, 4);

		// Transmit interrupt, last loopback frame still ends its stop bit
		write_reg(ADDR_CTRL, CTRL_IRQ_TX);
		wait_irq(1'b1, 2 * BIT_CYCLES);
		write_reg(ADDR_DATA, {24'd0, stim_bytes[8]});
		wait_irq(1'b0, 4);
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
		check("irq", {31'd0, irq}, 32'd0);
		poll_status(32'h0000_1F00, 32'h0000_0100, st);
		read_reg(ADDR_DATA, rd);
		check("rx data", rd, {24'd0, stim_bytes[8]});
		wait_irq(1'b1, 2 * FRAME_CYCLES);
		read_reg(ADDR_STATUS, rd);
		check("status", rd, status_word(0, 0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		$display("TEST PASS");
		$finish;
	end

endmodule

//--- uart_top.sv
module uart_top (
	input  logic              clock,
	input  logic              rst_n,
	input  uart_pkg::wb_req_t bus_req,
	output uart_pkg::wb_rsp_t bus_rsp,
	output logic              txd,
	input  logic              rxd,
	output logic              irq
);
	import uart_pkg::*;

	// TX path
	fifo_stat_t tx_stat;
	logic tx_push;
	logic [DATA_BITS-1:0] tx_wdata;
	logic tx_pop;
	logic [DATA_BITS-1:0] tx_rdata;
	logic tx_clear;
	logic tx_en;
	logic tx_busy;

	// RX path
	fifo_stat_t rx_stat;
	logic rx_push;
	logic [DATA_BITS-1:0] rx_wdata;
	logic rx_pop;
	logic [DATA_BITS-1:0] rx_rdata;
	logic rx_clear;
	logic rx_en;
	logic overrun;
	logic frame_err;

	logic [BAUD_DIV_BITS-1:0] divisor;

	// Bus slave, status and interrupt
	uart_wb_regs regs (
		.clock     (clock),
		.rst_n     (rst_n),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.tx_stat   (tx_stat),
		.rx_stat   (rx_stat),
		.rx_data   (rx_rdata),
		.tx_busy   (tx_busy),
		.overrun   (overrun),
		.frame_err (frame_err),
		.tx_push   (tx_push),
		.tx_data   (tx_wdata),
		.rx_pop    (rx_pop),
		.tx_clear  (tx_clear),
		.rx_clear  (rx_clear),
		.divisor   (divisor),
		.tx_en     (tx_en),
		.rx_en     (rx_en),
		.irq       (irq)
	);

	sync_fifo tx_fifo (
		.clock     (clock),
		.rst_n     (rst_n),
		.clear     (tx_clear),
		.push      (tx_push),
		.push_data (tx_wdata),
		.pop       (tx_pop),
		.pop_data  (tx_rdata),
		.stat      (tx_stat)
	);

	sync_fifo rx_fifo (
		.clock     (clock),
		.rst_n     (rst_n),
		.clear     (rx_clear),
		.push      (rx_push),
		.push_data (rx_wdata),
		.pop       (rx_pop),
		.pop_data  (rx_rdata),
		.stat      (rx_stat)
	);

	uart_transmitter transmitter (
		.clock     (clock),
		.rst_n     (rst_n),
		.enable    (tx_en),
		.divisor   (divisor),
		.fifo_stat (tx_stat),
		.fifo_data (tx_rdata),
		.fifo_pop  (tx_pop),
		.busy      (tx_busy),
		.txd       (txd)
	);

	uart_receiver receiver (
		.clock     (clock),
		.rst_n     (rst_n),
		.enable    (rx_en),
		.divisor   (divisor),
		.rxd       (rxd),
		.fifo_stat (rx_stat),
		.fifo_push (rx_push),
		.fifo_data (rx_wdata),
		.overrun   (overrun),
		.frame_err (frame_err)
	);

endmodule

//--- uart_transmitter.sv
module uart_transmitter (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               enable,
	input  logic [uart_pkg::BAUD_DIV_BITS-1:0] divisor,
	input  uart_pkg::fifo_stat_t               fifo_stat,
	input  logic [uart_pkg::DATA_BITS-1:0]     fifo_data,
	output logic                               fifo_pop,
	output logic                               busy,
	output logic                               txd
);
	import uart_pkg::*;

	tx_state_e state;
	logic [BAUD_DIV_BITS-1:0] cnt;
	// Divisor held for the current bit
	logic [BAUD_DIV_BITS-1:0] bit_div;
	logic [BIT_IDX_BITS-1:0] bit_idx;
	logic [DATA_BITS-1:0] shreg;
	logic bit_end;

	// Take one byte when idle and allowed
	assign fifo_pop = (state == TX_IDLE) && enable && !fifo_stat.empty;
	assign bit_end = (cnt == bit_div - 1'b1);

	// Busy from the pop cycle through the stop bit
	assign busy = (state != TX_IDLE) || fifo_pop;

	// Payload and per-bit divisor
	always_ff @(posedge clock) begin
		if (fifo_pop) begin
			shreg <= fifo_data;
			bit_div <= divisor;
		end else if (state != TX_IDLE && bit_end) begin
			// New divisor only at a bit boundary
			bit_div <= divisor;
			if (state == TX_START || state == TX_DATA) begin
				shreg <= shreg >> 1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					if (fifo_pop) begin
						// Start bit
						state <= TX_START;
						txd <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state <= TX_DATA;
						cnt <= '0;
						bit_idx <= '0;
						// LSB first
						txd <= shreg[0];
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == BIT_IDX_BITS'(DATA_BITS - 1)) begin
							state <= TX_STOP;
							txd <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd <= shreg[0];
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Line rests high between frames
	a_idle_high: assert property (@(posedge clock) disable iff (!rst_n)
		(state == TX_IDLE) |-> txd);

endmodule

//--- uart_wb_regs.sv
module uart_wb_regs (
	input  logic                               clock,
	input  logic                               rst_n,
	input  uart_pkg::wb_req_t                  bus_req,
	output uart_pkg::wb_rsp_t                  bus_rsp,
	input  uart_pkg::fifo_stat_t               tx_stat,
	input  uart_pkg::fifo_stat_t               rx_stat,
	input  logic [uart_pkg::DATA_BITS-1:0]     rx_data,
	input  logic                               tx_busy,
	input  logic                               overrun,
	input  logic                               frame_err,
	output logic                               tx_push,
	output logic [uart_pkg::DATA_BITS-1:0]     tx_data,
	output logic                               rx_pop,
	output logic                               tx_clear,
	output logic                               rx_clear,
	output logic [uart_pkg::BAUD_DIV_BITS-1:0] divisor,
	output logic                               tx_en,
	output logic                               rx_en,
	output logic                               irq
);
	import uart_pkg::*;

	uart_ctrl_t ctrl;
	reg_addr_e addr;
	logic ack;
	logic wr_acc;
	logic rd_acc;
	logic overrun_q;
	logic frame_err_q;
	logic status_rd;
	logic [31:0] rdata;

	// One-cycle ack, then drop while master removes stb
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= bus_req.cyc && bus_req.stb && !ack;
		end
	end

	assign addr = reg_addr_e'(bus_req.adr[3:2]);

	// Side effects only in the ack cycle
	assign wr_acc = ack && bus_req.we;
	assign rd_acc = ack && !bus_req.we;
	assign status_rd = rd_acc && (addr == REG_STATUS);

	// Full FIFO drops the byte silently
	assign tx_push = wr_acc && (addr == REG_DATA) && !tx_stat.full;
	assign tx_data = bus_req.dat[DATA_BITS-1:0];
	assign rx_pop = rd_acc && (addr == REG_DATA) && !rx_stat.empty;

	// Self-clearing bits 8 and 9
	assign tx_clear = wr_acc && (addr == REG_CTRL) && bus_req.dat[8];
	assign rx_clear = wr_acc && (addr == REG_CTRL) && bus_req.dat[9];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (wr_acc && addr == REG_CTRL) begin
			ctrl <= uart_ctrl_t'(bus_req.dat[7:0]);
		end
	end

	assign tx_en = ctrl.tx_en;
	assign rx_en = ctrl.rx_en;

	// Sticky errors; a new event beats the read clear
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			overrun_q <= 1'b0;
			frame_err_q <= 1'b0;
		end else begin
			if (overrun) begin
				overrun_q <= 1'b1;
			end else if (status_rd) begin
				overrun_q <= 1'b0;
			end
			if (frame_err) begin
				frame_err_q <= 1'b1;
			end else if (status_rd) begin
				frame_err_q <= 1'b0;
			end
		end
	end

	// Divisor lookup and interrupt, both registered
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			divisor <= baud_div_table[0];
			irq <= 1'b0;
		end else begin
			divisor <= baud_div_table[ctrl.baud];
			irq <= (ctrl.irq_rx_en && !rx_stat.empty) ||
				(ctrl.irq_tx_en && tx_stat.empty && !tx_busy);
		end
	end

	// Read mux
	always_comb begin
		case (addr)
			REG_DATA: rdata = {24'd0, rx_stat.empty ? 8'h00 : rx_data};
			REG_STATUS: rdata = {11'd0, frame_err_q, overrun_q, tx_busy,
				rx_stat.empty, tx_stat.full, 3'd0, rx_stat.count, 3'd0, tx_stat.count};
			REG_CTRL: rdata = {24'd0, ctrl};
			default: rdata = 32'd0;
		endcase
	end

	always_comb begin
		bus_rsp.ack = ack;
		bus_rsp.dat = ack ? rdata : 32'd0;
	end

	// Master must hold the request through ack
	a_ack_in_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		bus_rsp.ack |-> (bus_req.cyc && bus_req.stb));

endmodule
